//--- qr_fixed_pkg.sv
`default_nettype none

package qr_fixed_pkg;

	// ------------------------------------------------------------------------
	// Sample formats
	// ------------------------------------------------------------------------
	typedef logic        [47:0] in_word_t;  // Raw word from the input bus
	typedef logic signed [15:0] sample_t;   // One real or imaginary part

	// Two 14-bit signed fields per input word
	localparam int FIELD_RE_MSB = 47;
	localparam int FIELD_IM_MSB = 23;
	localparam int FIELD_W      = 14;

	// ------------------------------------------------------------------------
	// Gain compensation
	// ------------------------------------------------------------------------
	// Inverse of the CORDIC gain, about 0.6073
	localparam int GAIN_COMP  = 19898;      // Q15
	localparam int GAIN_SHIFT = 15;

endpackage

`default_nettype wire

//--- qr_ctrl_pkg.sv
`default_nettype none

package qr_ctrl_pkg;

	// ------------------------------------------------------------------------
	// Sequencer
	// ------------------------------------------------------------------------
	typedef enum logic [2:0] {
		IDLE,
		CAPTURE,    // Waiting for a full frame
		READ,       // Read strobe to the sample buffer
		RUN,        // CORDIC pair busy on one RE
		EMIT
	} seq_state_t;

	// Frame layout, h word first and y word second
	localparam int WORDS_PER_RE = 2;

	// Defaults handed down from the top level
	localparam int NUM_RE_DEF   = 10;
	localparam int ITER_NUM_DEF = 9;

endpackage

`default_nettype wire

//--- re_sample_buffer.sv
`default_nettype none

module re_sample_buffer #(
	parameter int NUM_RE = qr_ctrl_pkg::NUM_RE_DEF
) (
	input  logic                        i_clk,
	input  logic                        i_rst,
	input  logic                        i_trig,
	input  logic                        i_cap_en,
	input  qr_fixed_pkg::in_word_t      i_data,
	input  logic                        i_rd_en,
	input  logic [$clog2(NUM_RE)-1:0]   i_rd_re,
	output logic                        o_frame_full,
	output logic                        o_smp_vld,
	output qr_fixed_pkg::sample_t       o_h_re,
	output qr_fixed_pkg::sample_t       o_h_im,
	output qr_fixed_pkg::sample_t       o_y_re,
	output qr_fixed_pkg::sample_t       o_y_im
);
	import qr_fixed_pkg::*;
	import qr_ctrl_pkg::*;

	localparam int FRAME_WORDS = WORDS_PER_RE * NUM_RE;
	localparam int CNT_W       = $clog2(FRAME_WORDS + 1);
	localparam int RE_W        = $clog2(NUM_RE);

	typedef logic [2*FIELD_W-1:0] field_pair_t;  // Real field above imaginary

	field_pair_t      h_bank [NUM_RE];
	field_pair_t      y_bank [NUM_RE];
	field_pair_t      wr_word;
	field_pair_t      h_q;
	field_pair_t      y_q;
	logic [CNT_W-1:0] wr_cnt;
	logic [RE_W-1:0]  wr_re;
	logic             wr_en;
	logic             rd_vld_q;

	function automatic sample_t sext(input logic [FIELD_W-1:0] f);
		return {{($bits(sample_t) - FIELD_W){f[FIELD_W-1]}}, f};
	endfunction

	// ------------------------------------------------------------------------
	// Capture side
	// ------------------------------------------------------------------------
	assign wr_en   = i_cap_en && i_trig && (wr_cnt < CNT_W'(FRAME_WORDS));
	assign wr_re   = RE_W'(wr_cnt / WORDS_PER_RE);
	assign wr_word = {i_data[FIELD_RE_MSB -: FIELD_W], i_data[FIELD_IM_MSB -: FIELD_W]};

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			wr_cnt       <= '0;
			o_frame_full <= 1'b0;
		end else begin
			o_frame_full <= wr_en && (wr_cnt == CNT_W'(FRAME_WORDS - 1));
			if (!i_trig) begin
				wr_cnt <= '0;            // Trigger gap restarts the frame
			end else if (wr_en) begin
				wr_cnt <= wr_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (wr_en) begin
			if (wr_cnt[0]) begin
				y_bank[wr_re] <= wr_word;  // Odd word is y
			end else begin
				h_bank[wr_re] <= wr_word;
			end
		end
	end

	// ------------------------------------------------------------------------
	// Read side, bank read then output register
	// ------------------------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (i_rd_en) begin
			h_q <= h_bank[i_rd_re];
			y_q <= y_bank[i_rd_re];
		end
		o_h_re <= sext(h_q[FIELD_W +: FIELD_W]);
		o_h_im <= sext(h_q[0 +: FIELD_W]);
		o_y_re <= sext(y_q[FIELD_W +: FIELD_W]);
		o_y_im <= sext(y_q[0 +: FIELD_W]);
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			rd_vld_q  <= 1'b0;
			o_smp_vld <= 1'b0;
		end else begin
			rd_vld_q  <= i_rd_en;
			o_smp_vld <= rd_vld_q;
		end
	end

	// Capture closes right after a full frame, so no word lands past the end
	a_no_overrun: assert property (@(posedge i_clk) disable iff (i_rst)
		o_frame_full |=> !i_cap_en);

endmodule

`default_nettype wire

//--- qr_sequencer.sv
`default_nettype none

module qr_sequencer #(
	parameter int NUM_RE = qr_ctrl_pkg::NUM_RE_DEF
) (
	input  logic                        i_clk,
	input  logic                        i_rst,
	input  logic                        i_frame_full,
	input  logic                        i_done,
	output logic                        o_cap_en,
	output logic                        o_rd_en,
	output logic [$clog2(NUM_RE)-1:0]   o_rd_re,
	output logic                        o_last_re
);
	import qr_ctrl_pkg::*;

	localparam int RE_W = $clog2(NUM_RE);

	seq_state_t      state;
	seq_state_t      next_state;
	logic [RE_W-1:0] re_cnt;
	logic            re_is_last;

	assign re_is_last = (re_cnt == RE_W'(NUM_RE - 1));

	// ------------------------------------------------------------------------
	// FSM
	// ------------------------------------------------------------------------
	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			IDLE:    next_state = CAPTURE;
			CAPTURE: begin
				if (i_frame_full) begin
					next_state = READ;
				end
			end
			READ:    next_state = RUN;
			RUN: begin
				if (i_done) begin
					next_state = EMIT;    // Result registered this edge
				end
			end
			EMIT:    next_state = re_is_last ? IDLE : READ;
			default: next_state = IDLE;
		endcase
	end

	// RE counter, wraps after the last RE of the frame
	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			re_cnt <= '0;
		end else if (state == EMIT) begin
			if (re_is_last) begin
				re_cnt <= '0;
			end else begin
				re_cnt <= re_cnt + 1'b1;
			end
		end
	end

	assign o_cap_en  = (state == IDLE) || (state == CAPTURE);
	assign o_rd_en   = (state == READ);
	assign o_rd_re   = re_cnt;
	assign o_last_re = re_is_last && !o_cap_en;

	// One RE in flight, so a CORDIC pass can only finish while we wait in RUN
	a_done_in_run: assert property (@(posedge i_clk) disable iff (i_rst)
		i_done |-> (state == RUN));

endmodule

`default_nettype wire

//--- cordic_vectoring.sv
`default_nettype none

module cordic_vectoring #(
	parameter int ITER_NUM = qr_ctrl_pkg::ITER_NUM_DEF
) (
	input  logic                  i_clk,
	input  logic                  i_rst,
	input  logic                  i_start,
	input  qr_fixed_pkg::sample_t i_re,
	input  qr_fixed_pkg::sample_t i_im,
	output logic                  o_flip,
	output logic                  o_dir_vld,
	output logic                  o_dir,
	output logic                  o_done,
	output qr_fixed_pkg::sample_t o_mag
);
	import qr_fixed_pkg::*;

	localparam int K_W = $clog2(ITER_NUM);

	sample_t        x;
	sample_t        y;
	logic           busy;
	logic [K_W-1:0] k;
	logic           last_iter;

	// ------------------------------------------------------------------------
	// Decisions shared with the rotation unit
	// ------------------------------------------------------------------------
	assign o_flip    = i_start && i_re[$bits(sample_t)-1];  // Left half-plane
	assign o_dir_vld = busy;
	assign o_dir     = !y[$bits(sample_t)-1];              // Imag part >= 0
	assign last_iter = busy && (k == K_W'(ITER_NUM - 1));

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			busy   <= 1'b0;
			k      <= '0;
			o_done <= 1'b0;
		end else begin
			o_done <= last_iter;
			if (i_start) begin
				busy <= 1'b1;
				k    <= '0;
			end else if (last_iter) begin
				busy <= 1'b0;
			end else if (busy) begin
				k <= k + 1'b1;
			end
		end
	end

	// ------------------------------------------------------------------------
	// Datapath, half-turn on start then one micro-rotation per cycle
	// ------------------------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (i_start) begin
			x <= o_flip ? -i_re : i_re;
			y <= o_flip ? -i_im : i_im;
		end else if (busy) begin
			if (o_dir) begin
				x <= x + (y >>> k);     // Clockwise step
				y <= y - (x >>> k);
			end else begin
				x <= x - (y >>> k);
				y <= y + (x >>> k);
			end
		end
	end

	// Magnitude still scaled by the CORDIC gain
	assign o_mag = x;

	// Sequencer waits for o_done before the next read
	a_no_restart: assert property (@(posedge i_clk) disable iff (i_rst)
		i_start |-> !busy);

endmodule

`default_nettype wire

//--- cordic_rotation.sv
`default_nettype none

module cordic_rotation #(
	parameter int ITER_NUM = qr_ctrl_pkg::ITER_NUM_DEF
) (
	input  logic                  i_clk,
	input  logic                  i_rst,
	input  logic                  i_start,
	input  qr_fixed_pkg::sample_t i_re,
	input  qr_fixed_pkg::sample_t i_im,
	input  logic                  i_flip,
	input  logic                  i_dir_vld,
	input  logic                  i_dir,
	output logic                  o_done,
	output qr_fixed_pkg::sample_t o_re,
	output qr_fixed_pkg::sample_t o_im
);
	import qr_fixed_pkg::*;

	localparam int K_W = $clog2(ITER_NUM);

	sample_t        x;
	sample_t        y;
	logic           busy;
	logic [K_W-1:0] k;
	logic           last_iter;

	assign last_iter = busy && (k == K_W'(ITER_NUM - 1));

	// Own iteration count, kept in step with the vectoring unit
	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			busy   <= 1'b0;
			k      <= '0;
			o_done <= 1'b0;
		end else begin
			o_done <= last_iter;
			if (i_start) begin
				busy <= 1'b1;
				k    <= '0;
			end else if (last_iter) begin
				busy <= 1'b0;
			end else if (busy) begin
				k <= k + 1'b1;
			end
		end
	end

	// ------------------------------------------------------------------------
	// Follow the received decisions
	// ------------------------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (i_start) begin
			x <= i_flip ? -i_re : i_re;
			y <= i_flip ? -i_im : i_im;
		end else if (i_dir_vld) begin
			if (i_dir) begin
				x <= x + (y >>> k);
				y <= y - (x >>> k);
			end else begin
				x <= x - (y >>> k);
				y <= y + (x >>> k);
			end
		end
	end

	assign o_re = x;
	assign o_im = y;

	// Decisions must line up with our own pass
	a_dir_in_pass: assert property (@(posedge i_clk) disable iff (i_rst)
		i_dir_vld |-> busy);

endmodule

`default_nettype wire

//--- qr_result_assembler.sv
`default_nettype none

module qr_result_assembler (
	input  logic                                   i_clk,
	input  logic                                   i_rst,
	input  logic                                   i_done,
	input  logic                                   i_last_re,
	input  qr_fixed_pkg::sample_t                  i_mag,
	input  qr_fixed_pkg::sample_t                  i_y_re,
	input  qr_fixed_pkg::sample_t                  i_y_im,
	output logic                                   o_rd_vld,
	output logic                                   o_last_data,
	output qr_fixed_pkg::sample_t                  o_r,
	output logic [2*$bits(qr_fixed_pkg::sample_t)-1:0] o_y_hat
);
	import qr_fixed_pkg::*;

	typedef logic signed [31:0] prod_t;  // Full product before rounding

	sample_t r_fix;
	sample_t y_re_fix;
	sample_t y_im_fix;

	// Multiply by 1/K, round half up, back to sample width
	function automatic sample_t gain_fix(input sample_t v);
		prod_t p;
		p = prod_t'(v) * prod_t'(GAIN_COMP) + (prod_t'(1) <<< (GAIN_SHIFT - 1));
		return sample_t'(p >>> GAIN_SHIFT);
	endfunction

	assign r_fix    = gain_fix(i_mag);
	assign y_re_fix = gain_fix(i_y_re);
	assign y_im_fix = gain_fix(i_y_im);

	// ------------------------------------------------------------------------
	// Output registers
	// ------------------------------------------------------------------------
	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			o_rd_vld    <= 1'b0;
			o_last_data <= 1'b0;
			o_r         <= '0;
			o_y_hat     <= '0;
		end else begin
			o_rd_vld    <= i_done;
			o_last_data <= i_done && i_last_re;  // Final RE of the frame
			if (i_done) begin
				o_r     <= r_fix;
				o_y_hat <= {y_im_fix, y_re_fix};  // Imaginary on top
			end
		end
	end

endmodule

`default_nettype wire

//--- qr_engine.sv
`default_nettype none

module qr_engine #(
	parameter int NUM_RE   = qr_ctrl_pkg::NUM_RE_DEF,
	parameter int ITER_NUM = qr_ctrl_pkg::ITER_NUM_DEF
) (
	input  logic                                   i_clk,
	input  logic                                   i_rst,
	input  logic                                   i_trig,
	input  qr_fixed_pkg::in_word_t                 i_data,
	output logic                                   o_rd_vld,
	output logic                                   o_last_data,
	output qr_fixed_pkg::sample_t                  o_r,
	output logic [2*$bits(qr_fixed_pkg::sample_t)-1:0] o_y_hat
);
	import qr_fixed_pkg::*;

	localparam int RE_W = $clog2(NUM_RE);

	logic            cap_en;
	logic            frame_full;
	logic            rd_en;
	logic [RE_W-1:0] rd_re;
	logic            last_re;
	logic            smp_vld;      // Start strobe for both CORDIC units
	sample_t         h_re;
	sample_t         h_im;
	sample_t         y_re;
	sample_t         y_im;
	logic            flip;
	logic            dir_vld;
	logic            dir;
	logic            vec_done;
	logic            rot_done;
	sample_t         mag;
	sample_t         rot_re;
	sample_t         rot_im;

	// ------------------------------------------------------------------------
	// Sample store and control
	// ------------------------------------------------------------------------
	re_sample_buffer #(.NUM_RE(NUM_RE)) u_buf (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_trig       (i_trig),
		.i_cap_en     (cap_en),
		.i_data       (i_data),
		.i_rd_en      (rd_en),
		.i_rd_re      (rd_re),
		.o_frame_full (frame_full),
		.o_smp_vld    (smp_vld),
		.o_h_re       (h_re),
		.o_h_im       (h_im),
		.o_y_re       (y_re),
		.o_y_im       (y_im)
	);

	// Both CORDIC units finish on the same cycle
	qr_sequencer #(.NUM_RE(NUM_RE)) u_seq (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_frame_full (frame_full),
		.i_done       (rot_done),
		.o_cap_en     (cap_en),
		.o_rd_en      (rd_en),
		.o_rd_re      (rd_re),
		.o_last_re    (last_re)
	);

	// ------------------------------------------------------------------------
	// CORDIC pair and output stage
	// ------------------------------------------------------------------------
	cordic_vectoring #(.ITER_NUM(ITER_NUM)) u_vec (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_start   (smp_vld),
		.i_re      (h_re),
		.i_im      (h_im),
		.o_flip    (flip),
		.o_dir_vld (dir_vld),
		.o_dir     (dir),
		.o_done    (vec_done),
		.o_mag     (mag)
	);

	cordic_rotation #(.ITER_NUM(ITER_NUM)) u_rot (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_start   (smp_vld),
		.i_re      (y_re),
		.i_im      (y_im),
		.i_flip    (flip),
		.i_dir_vld (dir_vld),
		.i_dir     (dir),
		.o_done    (rot_done),
		.o_re      (rot_re),
		.o_im      (rot_im)
	);

	qr_result_assembler u_asm (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_done      (vec_done),
		.i_last_re   (last_re),
		.i_mag       (mag),
		.i_y_re      (rot_re),
		.i_y_im      (rot_im),
		.o_rd_vld    (o_rd_vld),
		.o_last_data (o_last_data),
		.o_r         (o_r),
		.o_y_hat     (o_y_hat)
	);

endmodule

`default_nettype wire

//--- tb_qr_engine.sv
`default_nettype none

module tb_qr_engine;
	import qr_fixed_pkg::*;
	import qr_ctrl_pkg::*;

	localparam int NUM_RE           = NUM_RE_DEF;
	localparam int ITER_NUM         = ITER_NUM_DEF;
	localparam int HALF_PERIOD      = 50;
	localparam int TABLE_FRAMES     = 2;
	localparam int RAND_FRAMES      = 4;
	localparam int NUM_FRAMES       = TABLE_FRAMES + RAND_FRAMES;
	localparam int CYCLES_PER_FRAME = 4000;
	localparam int WATCHDOG_CYCLES  = CYCLES_PER_FRAME * NUM_FRAMES + 100;

	logic        i_clk;
	logic        i_rst;
	logic        i_trig;
	in_word_t    i_data;
	logic        o_rd_vld;
	logic        o_last_data;
	sample_t     o_r;
	logic [31:0] o_y_hat;

	logic [31:0] rng;
	logic [55:0] cur_frame [NUM_RE];   // 14-bit h_re h_im y_re y_im from the top
	int          value_errors;
	int          flag_errors;
	int          count_errors;
	int          vld_total;

	// ------------------------------------------------------------------------
	// Stimulus table with one row per RE and NUM_RE rows per frame
	// ------------------------------------------------------------------------
	logic [55:0] stim_table [TABLE_FRAMES*NUM_RE] = '{
		{14'sd4000, 14'sd1500, 14'sd1200, -14'sd300},    // Positive h
		{-14'sd3000, 14'sd2000, 14'sd500, 14'sd700},     // Negative real part
		{14'sd0, 14'sd5000, -14'sd800, 14'sd2500},       // Purely imaginary
		{14'sd0, -14'sd5000, 14'sd3000, -14'sd3000},
		{14'sd0, 14'sd0, 14'sd1000, 14'sd2000},          // Zero h
		{14'sd8191, 14'sd8191, 14'sd8191, 14'sd8191},    // Full scale
		{14'h2000, 14'h2000, 14'h2000, 14'h2000},
		{-14'sd6000, -14'sd100, -14'sd4000, 14'sd4000},
		{14'sd1, 14'sd0, 14'sd1, 14'sd1},
		{14'sd8191, 14'sd0, 14'h2000, 14'sd8191},
		{14'h2000, 14'sd0, 14'sd100, -14'sd100},
		{14'sd0, 14'h2000, 14'sd50, 14'sd60},
		{14'sd0, 14'sd8191, -14'sd7000, 14'sd1},
		{-14'sd1, 14'sd0, 14'sd0, 14'sd0},
		{14'sd100, -14'sd100, -14'sd100, 14'sd100},
		{14'sd7000, -14'sd7000, 14'sd0, 14'sd0},
		{-14'sd500, 14'sd6000, 14'sd3000, -14'sd3000},
		{14'sd2000, 14'sd1, -14'sd2000, -14'sd1},
		{14'sd0, 14'sd0, 14'sd0, 14'sd0},
		{-14'sd4096, 14'sd4096, 14'sd8191, -14'sd8191}
	};

	qr_engine #(
		.NUM_RE   (NUM_RE),
		.ITER_NUM (ITER_NUM)
	) u_dut (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_trig      (i_trig),
		.i_data      (i_data),
		.o_rd_vld    (o_rd_vld),
		.o_last_data (o_last_data),
		.o_r         (o_r),
		.o_y_hat     (o_y_hat)
	);

	initial begin
		i_clk = 1'b0;
		forever #HALF_PERIOD i_clk = ~i_clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] v;
		v = s;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	// Fields at 47..34 and 23..10 with filler in the ignored bits
	function automatic in_word_t pack_word(input logic [13:0] re, input logic [13:0] im,
			input logic [19:0] filler);
		return {re, filler[19:10], im, filler[9:0]};
	endfunction

	function automatic sample_t round_gain(input sample_t v);
		int p;
		p = int'(v) * GAIN_COMP + (1 <<< (GAIN_SHIFT - 1));
		return sample_t'(p >>> GAIN_SHIFT);
	endfunction

	// ------------------------------------------------------------------------
	// Reference model returning {R11, y imag, y real}
	// ------------------------------------------------------------------------
	function automatic logic [47:0] predict(input logic [55:0] ent);
		sample_t hx;
		sample_t hy;
		sample_t yx;
		sample_t yy;
		sample_t hx_n;
		sample_t hy_n;
		sample_t yx_n;
		sample_t yy_n;
		logic    d;
		hx = {{2{ent[55]}}, ent[55:42]};
		hy = {{2{ent[41]}}, ent[41:28]};
		yx = {{2{ent[27]}}, ent[27:14]};
		yy = {{2{ent[13]}}, ent[13:0]};
		if (hx < 0) begin           // Half turn into the right half-plane
			hx = -hx;
			hy = -hy;
			yx = -yx;
			yy = -yy;
		end
		for (int k = 0; k < ITER_NUM; k++) begin
			d = (hy >= 0);
			if (d) begin
				hx_n = hx + (hy >>> k);
				hy_n = hy - (hx >>> k);
				yx_n = yx + (yy >>> k);
				yy_n = yy - (yx >>> k);
			end else begin
				hx_n = hx - (hy >>> k);
				hy_n = hy + (hx >>> k);
				yx_n = yx - (yy >>> k);
				yy_n = yy + (yx >>> k);
			end
			hx = hx_n;
			hy = hy_n;
			yx = yx_n;
			yy = yy_n;
		end
		return {round_gain(hx), round_gain(yy), round_gain(yx)};
	endfunction

	// ------------------------------------------------------------------------
	// Driving and checking
	// ------------------------------------------------------------------------
	task automatic send_frame();
		for (int i = 0; i < NUM_RE; i++) begin
			@(negedge i_clk);
			rng    = xorshift32(rng);
			i_trig = 1'b1;
			i_data = pack_word(cur_frame[i][55:42], cur_frame[i][41:28], rng[19:0]);
			@(negedge i_clk);
			i_data = pack_word(cur_frame[i][27:14], cur_frame[i][13:0], rng[31:12]);
		end
		@(negedge i_clk);
		i_trig = 1'b0;
		i_data = '0;
	endtask

	// Trigger bursts as long as a whole frame while the frame is in process
	task automatic pulse_trig_noise();
		repeat (3) begin
			repeat (3) @(negedge i_clk);
			i_trig = 1'b1;
			repeat (WORDS_PER_RE * NUM_RE) begin
				rng    = xorshift32(rng);
				i_data = {rng[15:0], rng};
				@(negedge i_clk);
			end
			i_trig = 1'b0;
		end
	endtask

	task automatic collect_results(input int frame_idx);
		int          got;
		logic [47:0] exp_v;
		got = 0;
		while (got < NUM_RE) begin
			@(negedge i_clk);
			if (o_rd_vld) begin
				exp_v = predict(cur_frame[got]);
				if (o_r !== exp_v[47:32]) begin
					value_errors++;
					$display("FAIL %0t: frame %0d RE %0d o_r %0d, expected %0d", $time,
						frame_idx, got, o_r, $signed(exp_v[47:32]));
				end
				if (o_y_hat !== exp_v[31:0]) begin
					value_errors++;
					$display("FAIL %0t: frame %0d RE %0d o_y_hat %h, expected %h", $time,
						frame_idx, got, o_y_hat, exp_v[31:0]);
				end
				if (o_last_data !== (got == NUM_RE - 1)) begin
					flag_errors++;
					$display("FAIL %0t: frame %0d RE %0d o_last_data %b", $time,
						frame_idx, got, o_last_data);
				end
				got++;
			end
		end
	endtask

	task automatic run_frame(input int frame_idx, input bit with_noise);
		send_frame();
		if (with_noise) begin
			fork
				pulse_trig_noise();
				collect_results(frame_idx);
			join
		end else begin
			collect_results(frame_idx);
		end
	endtask

	task automatic check_idle_outputs();
		if (o_rd_vld !== 1'b0 || o_last_data !== 1'b0) begin
			flag_errors++;
			$display("FAIL %0t: flags not low after reset", $time);
		end
		if (o_r !== '0 || o_y_hat !== '0) begin
			value_errors++;
			$display("FAIL %0t: outputs not zero after reset", $time);
		end
	endtask

	// Counts every result pulse so that extra pulses show up at the end
	always @(negedge i_clk) begin
		if (!i_rst) begin
			if (o_rd_vld) begin
				vld_total++;
			end
			if (o_last_data && !o_rd_vld) begin
				flag_errors++;
				$display("FAIL %0t: o_last_data high without o_rd_vld", $time);
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge i_clk);
		$display("Timeout: the DUT did not deliver all results within %0d cycles",
			WATCHDOG_CYCLES);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		logic [27:0] hv;
		i_rst        = 1'b1;
		i_trig       = 1'b0;
		i_data       = '0;
		rng          = 32'd81272;
		value_errors = 0;
		flag_errors  = 0;
		count_errors = 0;
		vld_total    = 0;
		repeat (2) @(posedge i_clk);
		@(negedge i_clk);
		i_rst = 1'b0;
		check_idle_outputs();

		for (int f = 0; f < TABLE_FRAMES; f++) begin
			for (int i = 0; i < NUM_RE; i++) begin
				cur_frame[i] = stim_table[f*NUM_RE + i];
			end
			run_frame(f, f == 1);
		end

		for (int f = 0; f < RAND_FRAMES; f++) begin
			for (int i = 0; i < NUM_RE; i++) begin
				rng          = xorshift32(rng);
				hv           = rng[27:0];
				rng          = xorshift32(rng);
				cur_frame[i] = {hv, rng[27:0]};
			end
			run_frame(TABLE_FRAMES + f, 1'b1);
		end

		repeat (50) @(negedge i_clk);
		if (vld_total != NUM_FRAMES * NUM_RE) begin
			count_errors++;
			$display("FAIL %0t: %0d result pulses, expected %0d", $time, vld_total,
				NUM_FRAMES * NUM_RE);
		end
		$display("Errors: value %0d, flag %0d, count %0d", value_errors, flag_errors,
			count_errors);
		if (value_errors + flag_errors + count_errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
qr_fixed_pkg.sv
qr_ctrl_pkg.sv
re_sample_buffer.sv
qr_sequencer.sv
cordic_vectoring.sv
cordic_rotation.sv
qr_result_assembler.sv
qr_engine.sv
tb_qr_engine.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_qr_engine
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || (echo "No pass result in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
